//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_surf_bus_top
FILELIST  ?= surf_bus_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The status comes from the search, so a crash or a failing run both end non-zero
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- hw/surf_bus_defines.svh
`ifndef SURF_BUS_DEFINES_SVH
`define SURF_BUS_DEFINES_SVH

// Bus widths as seen by the masters
`define SURF_ADDR_W 22
`define SURF_DATA_W 32
`define SURF_SEL_W 4

`define SURF_NUM_MASTERS 2
`define SURF_NUM_TARGETS 6

// Target windows
// A target is selected when (adr & ~MASK) == BASE, and it sees adr & MASK.
// Bits 14 to 20 are set in every mask, so each window repeats higher up
`define SURF_ID_CTRL_BASE 22'h000000
`define SURF_ID_CTRL_MASK 22'h1FC7FF
`define SURF_TIO_BASE 22'h000800
`define SURF_TIO_MASK 22'h1FC7FF
`define SURF_NOTCH_BASE 22'h001000
`define SURF_NOTCH_MASK 22'h1FCFFF
`define SURF_AGC_BASE 22'h002000
`define SURF_AGC_MASK 22'h1FCFFF
`define SURF_BEAM_BASE 22'h003000
`define SURF_BEAM_MASK 22'h1FCFFF
// RFDC owns the whole upper half of the map
`define SURF_RFDC_BASE 22'h200000
`define SURF_RFDC_MASK 22'h1FFFFF

// Identification word, ASCII "SURF"
`define SURF_ID_WORD 32'h53555246

`endif

//--- hw/surf_bus_pkg.sv
`include "surf_bus_defines.svh"

package surf_bus_pkg;

    typedef logic [`SURF_ADDR_W-1:0] bus_addr_t;
    typedef logic [`SURF_DATA_W-1:0] bus_data_t;
    typedef logic [`SURF_SEL_W-1:0] bus_sel_t;

    // One bit per master, used for requests and grants
    typedef logic [`SURF_NUM_MASTERS-1:0] master_vec_t;

    // One bit per target, index order id/ctrl, tio, notch, agc, beam, rfdc
    typedef logic [`SURF_NUM_TARGETS-1:0] target_vec_t;

    typedef enum logic {
        ARB_IDLE,
        ARB_OWNED
    } arb_state_t;

endpackage

//--- hw/surf_bus_top.sv
`timescale 1ns/1ns
`include "surf_bus_defines.svh"

module surf_bus_top (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    // Board-management master
    input  logic                    bm_cyc_i, bm_stb_i, bm_we_i,
    input  surf_bus_pkg::bus_addr_t bm_adr_i,
    input  surf_bus_pkg::bus_data_t bm_dat_i,
    input  surf_bus_pkg::bus_sel_t  bm_sel_i,
    output surf_bus_pkg::bus_data_t bm_dat_o,
    output logic                    bm_ack_o, bm_err_o, bm_rty_o,
    // Crate backplane master
    input  logic                    rack_cyc_i, rack_stb_i, rack_we_i,
    input  surf_bus_pkg::bus_addr_t rack_adr_i,
    input  surf_bus_pkg::bus_data_t rack_dat_i,
    input  surf_bus_pkg::bus_sel_t  rack_sel_i,
    output surf_bus_pkg::bus_data_t rack_dat_o,
    output logic                    rack_ack_o, rack_err_o, rack_rty_o,
    // TURFIO target
    output logic                    tio_cyc_o, tio_stb_o, tio_we_o,
    output logic [10:0]             tio_adr_o,
    output surf_bus_pkg::bus_data_t tio_dat_o,
    output surf_bus_pkg::bus_sel_t  tio_sel_o,
    input  surf_bus_pkg::bus_data_t tio_dat_i,
    input  logic                    tio_ack_i, tio_err_i, tio_rty_i,
    // Notch filter target
    output logic                    notch_cyc_o, notch_stb_o, notch_we_o,
    output logic [11:0]             notch_adr_o,
    output surf_bus_pkg::bus_data_t notch_dat_o,
    output surf_bus_pkg::bus_sel_t  notch_sel_o,
    input  surf_bus_pkg::bus_data_t notch_dat_i,
    input  logic                    notch_ack_i, notch_err_i, notch_rty_i,
    // AGC target
    output logic                    agc_cyc_o, agc_stb_o, agc_we_o,
    output logic [11:0]             agc_adr_o,
    output surf_bus_pkg::bus_data_t agc_dat_o,
    output surf_bus_pkg::bus_sel_t  agc_sel_o,
    input  surf_bus_pkg::bus_data_t agc_dat_i,
    input  logic                    agc_ack_i, agc_err_i, agc_rty_i,
    // Beamformer target
    output logic                    beam_cyc_o, beam_stb_o, beam_we_o,
    output logic [11:0]             beam_adr_o,
    output surf_bus_pkg::bus_data_t beam_dat_o,
    output surf_bus_pkg::bus_sel_t  beam_sel_o,
    input  surf_bus_pkg::bus_data_t beam_dat_i,
    input  logic                    beam_ack_i, beam_err_i, beam_rty_i,
    // RFDC target, upper half of the map
    output logic                    rfdc_cyc_o, rfdc_stb_o, rfdc_we_o,
    output logic [17:0]             rfdc_adr_o,
    output surf_bus_pkg::bus_data_t rfdc_dat_o,
    output surf_bus_pkg::bus_sel_t  rfdc_sel_o,
    input  surf_bus_pkg::bus_data_t rfdc_dat_i,
    input  logic                    rfdc_ack_i, rfdc_err_i, rfdc_rty_i
);

    wb_if #(.ADDR_W(11)) id_ctrl ();
    wb_if #(.ADDR_W(11)) tio ();
    wb_if #(.ADDR_W(12)) notch ();
    wb_if #(.ADDR_W(12)) agc ();
    wb_if #(.ADDR_W(12)) beam ();
    wb_if #(.ADDR_W(18)) rfdc ();

    surf_intercon i_intercon (
        .clk_i, .rst_n_i,
        .bm_cyc_i, .bm_stb_i, .bm_we_i, .bm_adr_i, .bm_dat_i, .bm_sel_i,
        .bm_dat_o, .bm_ack_o, .bm_err_o, .bm_rty_o,
        .rack_cyc_i, .rack_stb_i, .rack_we_i, .rack_adr_i, .rack_dat_i, .rack_sel_i,
        .rack_dat_o, .rack_ack_o, .rack_err_o, .rack_rty_o,
        .id_ctrl, .tio, .notch, .agc, .beam, .rfdc
    );

    surf_id_ctrl i_id_ctrl (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .bus     (id_ctrl)
    );

    // External targets
    assign {tio_cyc_o, tio_stb_o, tio_we_o, tio_adr_o, tio_dat_o, tio_sel_o} =
        {tio.cyc, tio.stb, tio.we, tio.adr, tio.dat_w, tio.sel};
    assign {tio.dat_r, tio.ack, tio.err, tio.rty} =
        {tio_dat_i, tio_ack_i, tio_err_i, tio_rty_i};

    assign {notch_cyc_o, notch_stb_o, notch_we_o, notch_adr_o, notch_dat_o, notch_sel_o} =
        {notch.cyc, notch.stb, notch.we, notch.adr, notch.dat_w, notch.sel};
    assign {notch.dat_r, notch.ack, notch.err, notch.rty} =
        {notch_dat_i, notch_ack_i, notch_err_i, notch_rty_i};

    assign {agc_cyc_o, agc_stb_o, agc_we_o, agc_adr_o, agc_dat_o, agc_sel_o} =
        {agc.cyc, agc.stb, agc.we, agc.adr, agc.dat_w, agc.sel};
    assign {agc.dat_r, agc.ack, agc.err, agc.rty} =
        {agc_dat_i, agc_ack_i, agc_err_i, agc_rty_i};

    assign {beam_cyc_o, beam_stb_o, beam_we_o, beam_adr_o, beam_dat_o, beam_sel_o} =
        {beam.cyc, beam.stb, beam.we, beam.adr, beam.dat_w, beam.sel};
    assign {beam.dat_r, beam.ack, beam.err, beam.rty} =
        {beam_dat_i, beam_ack_i, beam_err_i, beam_rty_i};

    assign {rfdc_cyc_o, rfdc_stb_o, rfdc_we_o, rfdc_adr_o, rfdc_dat_o, rfdc_sel_o} =
        {rfdc.cyc, rfdc.stb, rfdc.we, rfdc.adr, rfdc.dat_w, rfdc.sel};
    assign {rfdc.dat_r, rfdc.ack, rfdc.err, rfdc.rty} =
        {rfdc_dat_i, rfdc_ack_i, rfdc_err_i, rfdc_rty_i};

endmodule

//--- hw/surf_id_ctrl.sv
`timescale 1ns/1ns
`include "surf_bus_defines.svh"

module surf_id_ctrl (
    input  logic clk_i,
    input  logic rst_n_i,
    wb_if.target bus
);

    logic [8:0]              word_off;
    logic                    req;
    logic                    ack_q;
    logic                    err_q;
    surf_bus_pkg::bus_data_t dat_q;
    surf_bus_pkg::bus_data_t ctrl_q;

    assign word_off = bus.adr[10:2];

    // Strobe not yet answered, so a held stb is not acked twice
    assign req = bus.cyc && bus.stb && !(ack_q || err_q);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
            err_q <= 1'b0;
        end else begin
            ack_q <= req && (word_off <= 9'd1);
            err_q <= req && (word_off > 9'd1);
        end
    end

    // Scratch/control word
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ctrl_q <= '0;
        end else if (req && bus.we && (word_off == 9'd1)) begin
            for (int b = 0; b < `SURF_SEL_W; b++) begin
                if (bus.sel[b]) begin
                    ctrl_q[8*b +: 8] <= bus.dat_w[8*b +: 8];
                end
            end
        end
    end

    // Read data is captured along with the response
    always_ff @(posedge clk_i) begin
        if (req) begin
            case (word_off)
                9'd0: dat_q <= `SURF_ID_WORD;
                9'd1: dat_q <= ctrl_q;
                default: dat_q <= '0;
            endcase
        end
    end

    assign bus.dat_r = dat_q;
    assign bus.ack   = ack_q;
    assign bus.err   = err_q;
    assign bus.rty   = 1'b0;

    assert property (@(posedge clk_i) disable iff (!rst_n_i) !(bus.ack && bus.err));

endmodule

//--- hw/surf_intercon.sv
`timescale 1ns/1ns
`include "surf_bus_defines.svh"

module surf_intercon (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    // Board-management master
    input  logic                    bm_cyc_i, bm_stb_i, bm_we_i,
    input  surf_bus_pkg::bus_addr_t bm_adr_i,
    input  surf_bus_pkg::bus_data_t bm_dat_i,
    input  surf_bus_pkg::bus_sel_t  bm_sel_i,
    output surf_bus_pkg::bus_data_t bm_dat_o,
    output logic                    bm_ack_o, bm_err_o, bm_rty_o,
    // Crate backplane master
    input  logic                    rack_cyc_i, rack_stb_i, rack_we_i,
    input  surf_bus_pkg::bus_addr_t rack_adr_i,
    input  surf_bus_pkg::bus_data_t rack_dat_i,
    input  surf_bus_pkg::bus_sel_t  rack_sel_i,
    output surf_bus_pkg::bus_data_t rack_dat_o,
    output logic                    rack_ack_o, rack_err_o, rack_rty_o,
    // Targets
    wb_if.host                      id_ctrl,
    wb_if.host                      tio,
    wb_if.host                      notch,
    wb_if.host                      agc,
    wb_if.host                      beam,
    wb_if.host                      rfdc
);

    localparam int NT = `SURF_NUM_TARGETS;

    localparam surf_bus_pkg::bus_addr_t BASE [NT] = '{
        `SURF_ID_CTRL_BASE, `SURF_TIO_BASE, `SURF_NOTCH_BASE,
        `SURF_AGC_BASE, `SURF_BEAM_BASE, `SURF_RFDC_BASE
    };
    localparam surf_bus_pkg::bus_addr_t MASK [NT] = '{
        `SURF_ID_CTRL_MASK, `SURF_TIO_MASK, `SURF_NOTCH_MASK,
        `SURF_AGC_MASK, `SURF_BEAM_MASK, `SURF_RFDC_MASK
    };

    surf_bus_pkg::master_vec_t req;
    surf_bus_pkg::master_vec_t gnt;
    logic                      owner;
    logic                      bus_cyc;
    logic                      bus_stb;
    logic                      bus_we;
    surf_bus_pkg::bus_addr_t   bus_adr;
    surf_bus_pkg::bus_data_t   bus_dat;
    surf_bus_pkg::bus_sel_t    bus_sel;
    surf_bus_pkg::target_vec_t tgt_sel;
    surf_bus_pkg::target_vec_t tgt_ack;
    surf_bus_pkg::target_vec_t tgt_err;
    surf_bus_pkg::target_vec_t tgt_rty;
    surf_bus_pkg::bus_addr_t   tgt_adr [NT];
    surf_bus_pkg::bus_data_t   tgt_dat [NT];
    surf_bus_pkg::bus_data_t   resp_dat;
    logic                      resp_ack;
    logic                      resp_err;
    logic                      resp_rty;

    assign req = {rack_cyc_i, bm_cyc_i};

    wishbone_arbiter i_arbiter (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .cyc_i   (req),
        .gnt_o   (gnt)
    );

    // Shared bus, only the granted master gets through
    assign owner   = gnt[1];
    assign bus_cyc = |(req & gnt);
    assign bus_stb = |({rack_stb_i, bm_stb_i} & gnt);
    assign bus_we  = owner ? rack_we_i  : bm_we_i;
    assign bus_adr = owner ? rack_adr_i : bm_adr_i;
    assign bus_dat = owner ? rack_dat_i : bm_dat_i;
    assign bus_sel = owner ? rack_sel_i : bm_sel_i;

    // Base/mask decode
    always_comb begin
        for (int i = 0; i < NT; i++) begin
            tgt_sel[i] = (bus_adr & ~MASK[i]) == BASE[i];
            tgt_adr[i] = bus_adr & MASK[i];
        end
    end

    assign {rfdc.cyc, beam.cyc, agc.cyc, notch.cyc, tio.cyc, id_ctrl.cyc} =
        {NT{bus_cyc}} & tgt_sel;
    assign {rfdc.stb, beam.stb, agc.stb, notch.stb, tio.stb, id_ctrl.stb} =
        {NT{bus_stb}} & tgt_sel;
    assign {rfdc.we, beam.we, agc.we, notch.we, tio.we, id_ctrl.we} = {NT{bus_we}};
    assign {rfdc.dat_w, beam.dat_w, agc.dat_w, notch.dat_w, tio.dat_w, id_ctrl.dat_w} =
        {NT{bus_dat}};
    assign {rfdc.sel, beam.sel, agc.sel, notch.sel, tio.sel, id_ctrl.sel} = {NT{bus_sel}};

    // Each target keeps only its own window bits
    assign id_ctrl.adr = tgt_adr[0][10:0];
    assign tio.adr     = tgt_adr[1][10:0];
    assign notch.adr   = tgt_adr[2][11:0];
    assign agc.adr     = tgt_adr[3][11:0];
    assign beam.adr    = tgt_adr[4][11:0];
    assign rfdc.adr    = tgt_adr[5][17:0];

    assign tgt_ack = {rfdc.ack, beam.ack, agc.ack, notch.ack, tio.ack, id_ctrl.ack};
    assign tgt_err = {rfdc.err, beam.err, agc.err, notch.err, tio.err, id_ctrl.err};
    assign tgt_rty = {rfdc.rty, beam.rty, agc.rty, notch.rty, tio.rty, id_ctrl.rty};
    assign tgt_dat = '{id_ctrl.dat_r, tio.dat_r, notch.dat_r,
                       agc.dat_r, beam.dat_r, rfdc.dat_r};

    assign resp_ack = |(tgt_ack & tgt_sel);
    assign resp_err = |(tgt_err & tgt_sel);
    assign resp_rty = |(tgt_rty & tgt_sel);

    always_comb begin
        resp_dat = '0;
        for (int i = 0; i < NT; i++) begin
            if (tgt_sel[i]) begin
                resp_dat = tgt_dat[i];
            end
        end
    end

    // Responses return to the granted master only
    assign bm_ack_o   = resp_ack & gnt[0];
    assign bm_err_o   = resp_err & gnt[0];
    assign bm_rty_o   = resp_rty & gnt[0];
    assign bm_dat_o   = gnt[0] ? resp_dat : '0;
    assign rack_ack_o = resp_ack & gnt[1];
    assign rack_err_o = resp_err & gnt[1];
    assign rack_rty_o = resp_rty & gnt[1];
    assign rack_dat_o = gnt[1] ? resp_dat : '0;

    // The map is fully covered with no overlap
    assert property (@(posedge clk_i) disable iff (!rst_n_i) bus_cyc |-> $onehot(tgt_sel));

endmodule

//--- hw/wb_if.sv
`timescale 1ns/1ns
`include "surf_bus_defines.svh"

// Wishbone classic link between the intercon and one target
interface wb_if #(
    parameter int ADDR_W = `SURF_ADDR_W
);
    logic                    cyc;
    logic                    stb;
    logic                    we;
    logic [ADDR_W-1:0]       adr;
    surf_bus_pkg::bus_data_t dat_w;
    surf_bus_pkg::bus_sel_t  sel;
    surf_bus_pkg::bus_data_t dat_r;
    logic                    ack;
    logic                    err;
    logic                    rty;

    modport host (
        output cyc, stb, we, adr, dat_w, sel,
        input  dat_r, ack, err, rty
    );

    modport target (
        input  cyc, stb, we, adr, dat_w, sel,
        output dat_r, ack, err, rty
    );

endinterface

//--- hw/wishbone_arbiter.sv
`timescale 1ns/1ns
`include "surf_bus_defines.svh"

module wishbone_arbiter (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  surf_bus_pkg::master_vec_t cyc_i,
    output surf_bus_pkg::master_vec_t gnt_o
);

    surf_bus_pkg::arb_state_t  state_q;
    surf_bus_pkg::master_vec_t gnt_q;
    // Index of the master that got the bus most recently
    logic                      last_q;
    logic                      pick;

    // Simultaneous requests go to the master that did not own the bus last
    always_comb begin
        if (cyc_i[0] && cyc_i[1]) begin
            pick = ~last_q;
        end else begin
            pick = cyc_i[1];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= surf_bus_pkg::ARB_IDLE;
            gnt_q   <= '0;
            last_q  <= 1'b1;
        end else begin
            case (state_q)
                surf_bus_pkg::ARB_IDLE: begin
                    if (|cyc_i) begin
                        state_q <= surf_bus_pkg::ARB_OWNED;
                        gnt_q   <= surf_bus_pkg::master_vec_t'(1) << pick;
                        last_q  <= pick;
                    end
                end
                surf_bus_pkg::ARB_OWNED: begin
                    // Owner dropped cyc, hand over at once if the other master waits
                    if (!cyc_i[last_q]) begin
                        if (|cyc_i) begin
                            gnt_q  <= surf_bus_pkg::master_vec_t'(1) << pick;
                            last_q <= pick;
                        end else begin
                            state_q <= surf_bus_pkg::ARB_IDLE;
                            gnt_q   <= '0;
                        end
                    end
                end
                default: begin
                    state_q <= surf_bus_pkg::ARB_IDLE;
                    gnt_q   <= '0;
                end
            endcase
        end
    end

    assign gnt_o = gnt_q;

    assert property (@(posedge clk_i) disable iff (!rst_n_i) $onehot0(gnt_o));

    // No preemption while the owner holds its cycle
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (|(gnt_o & cyc_i)) |=> $stable(gnt_o));

endmodule

//--- surf_bus_top.f
+incdir+hw
hw/surf_bus_pkg.sv
hw/wb_if.sv
hw/wishbone_arbiter.sv
hw/surf_intercon.sv
hw/surf_id_ctrl.sv
hw/surf_bus_top.sv
tb/tb_surf_bus_top.sv

//--- tb/tb_surf_bus_top.sv
`timescale 1ns/1ns
`include "surf_bus_defines.svh"

module tb_surf_bus_top;

    localparam int RSP_LIMIT = 40;
    // About 30 accesses of under 20 cycles each plus reset, with a wide margin
    localparam int CYCLE_LIMIT = 4000;
    localparam logic [2:0] RSP_ACK = 3'b100;
    localparam logic [2:0] RSP_ERR = 3'b010;
    localparam logic [2:0] RSP_RTY = 3'b001;
    localparam surf_bus_pkg::bus_addr_t SHADOW = 22'h1FC000;

    // Index 0 is id/ctrl, then tio, notch, agc, beam, rfdc
    localparam surf_bus_pkg::bus_addr_t BASE [6] = '{`SURF_ID_CTRL_BASE, `SURF_TIO_BASE,
        `SURF_NOTCH_BASE, `SURF_AGC_BASE, `SURF_BEAM_BASE, `SURF_RFDC_BASE};
    localparam surf_bus_pkg::bus_addr_t MASK [6] = '{`SURF_ID_CTRL_MASK, `SURF_TIO_MASK,
        `SURF_NOTCH_MASK, `SURF_AGC_MASK, `SURF_BEAM_MASK, `SURF_RFDC_MASK};
    // Address bits that fit on each target port
    localparam surf_bus_pkg::bus_addr_t WIN [6] = '{22'h0007FF, 22'h0007FF, 22'h000FFF,
        22'h000FFF, 22'h000FFF, 22'h03FFFF};
    localparam surf_bus_pkg::bus_data_t TAG [6] = '{32'h0, 32'h71000000, 32'h72000000,
        32'h73000000, 32'h74000000, 32'h75000000};

    logic                    clk_i;
    logic                    rst_n_i;
    logic [1:0]              m_cyc, m_stb, m_we, m_ack, m_err, m_rty, m_any;
    surf_bus_pkg::bus_addr_t m_adr [2];
    surf_bus_pkg::bus_data_t m_wdat [2];
    surf_bus_pkg::bus_data_t m_rdat [2];
    surf_bus_pkg::bus_sel_t  m_sel [2];
    logic [5:0]              t_cyc, t_stb, t_we, t_ack, t_err, t_rty;
    logic [17:0]             t_adr [6];
    surf_bus_pkg::bus_data_t t_wdat [6];
    surf_bus_pkg::bus_sel_t  t_sel [6];
    surf_bus_pkg::bus_data_t t_dat [6];
    logic [10:0]             tio_adr;
    logic [11:0]             notch_adr, agc_adr, beam_adr;
    logic [17:0]             rfdc_adr;
    int                      exp_tgt [2];
    surf_bus_pkg::bus_data_t exp_dat [2];
    logic [2:0]              exp_rsp [2];
    logic [2:0]              rsp_mode [6];
    logic [5:0]              pend;
    logic [17:0]             exp_a [6];
    logic [5:0]              exp_we;
    surf_bus_pkg::bus_data_t exp_wdat [6];
    surf_bus_pkg::bus_sel_t  exp_sel [6];
    logic                    arb_phase;
    logic [1:0]              last_m;
    int                      wait_tab [64];
    int                      wait_idx;
    int                      errors = 0;
    int                      err_mark = 0;
    int                      n_pass = 0;
    int                      n_fail = 0;
    int                      cycles = 0;

    surf_bus_top i_surf_bus_top (
        .clk_i (clk_i), .rst_n_i (rst_n_i),
        .bm_cyc_i (m_cyc[0]), .bm_stb_i (m_stb[0]), .bm_we_i (m_we[0]),
        .bm_adr_i (m_adr[0]), .bm_dat_i (m_wdat[0]), .bm_sel_i (m_sel[0]),
        .bm_dat_o (m_rdat[0]), .bm_ack_o (m_ack[0]), .bm_err_o (m_err[0]), .bm_rty_o (m_rty[0]),
        .rack_cyc_i (m_cyc[1]), .rack_stb_i (m_stb[1]), .rack_we_i (m_we[1]),
        .rack_adr_i (m_adr[1]), .rack_dat_i (m_wdat[1]), .rack_sel_i (m_sel[1]),
        .rack_dat_o (m_rdat[1]), .rack_ack_o (m_ack[1]), .rack_err_o (m_err[1]),
        .rack_rty_o (m_rty[1]),
        .tio_cyc_o (t_cyc[1]), .tio_stb_o (t_stb[1]), .tio_adr_o (tio_adr),
        .tio_we_o (t_we[1]), .tio_dat_o (t_wdat[1]), .tio_sel_o (t_sel[1]),
        .tio_dat_i (t_dat[1]), .tio_ack_i (t_ack[1]), .tio_err_i (t_err[1]), .tio_rty_i (t_rty[1]),
        .notch_cyc_o (t_cyc[2]), .notch_stb_o (t_stb[2]), .notch_adr_o (notch_adr),
        .notch_we_o (t_we[2]), .notch_dat_o (t_wdat[2]), .notch_sel_o (t_sel[2]),
        .notch_dat_i (t_dat[2]), .notch_ack_i (t_ack[2]), .notch_err_i (t_err[2]),
        .notch_rty_i (t_rty[2]),
        .agc_cyc_o (t_cyc[3]), .agc_stb_o (t_stb[3]), .agc_adr_o (agc_adr),
        .agc_we_o (t_we[3]), .agc_dat_o (t_wdat[3]), .agc_sel_o (t_sel[3]),
        .agc_dat_i (t_dat[3]), .agc_ack_i (t_ack[3]), .agc_err_i (t_err[3]), .agc_rty_i (t_rty[3]),
        .beam_cyc_o (t_cyc[4]), .beam_stb_o (t_stb[4]), .beam_adr_o (beam_adr),
        .beam_we_o (t_we[4]), .beam_dat_o (t_wdat[4]), .beam_sel_o (t_sel[4]),
        .beam_dat_i (t_dat[4]), .beam_ack_i (t_ack[4]), .beam_err_i (t_err[4]),
        .beam_rty_i (t_rty[4]),
        .rfdc_cyc_o (t_cyc[5]), .rfdc_stb_o (t_stb[5]), .rfdc_adr_o (rfdc_adr),
        .rfdc_we_o (t_we[5]), .rfdc_dat_o (t_wdat[5]), .rfdc_sel_o (t_sel[5]),
        .rfdc_dat_i (t_dat[5]), .rfdc_ack_i (t_ack[5]), .rfdc_err_i (t_err[5]),
        .rfdc_rty_i (t_rty[5])
    );

    assign t_cyc[0]  = 1'b0;
    assign t_stb[0]  = 1'b0;
    assign t_we[0]   = 1'b0;
    assign t_adr[0]  = '0;
    assign t_wdat[0] = '0;
    assign t_sel[0]  = '0;
    assign t_adr[1]  = 18'(tio_adr);
    assign t_adr[2]  = 18'(notch_adr);
    assign t_adr[3]  = 18'(agc_adr);
    assign t_adr[4]  = 18'(beam_adr);
    assign t_adr[5]  = rfdc_adr;
    assign m_any     = m_ack | m_err | m_rty;

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // Address and write side that each external target should see for the cycles now open
    always_comb begin
        pend   = '0;
        exp_we = '0;
        for (int t = 0; t < 6; t++) begin
            exp_a[t]    = '0;
            exp_wdat[t] = '0;
            exp_sel[t]  = '0;
        end
        for (int m = 0; m < 2; m++) begin
            if (m_cyc[m] && exp_tgt[m] > 0) begin
                pend[exp_tgt[m]] = 1'b1;
                exp_a[exp_tgt[m]] = 18'(m_adr[m] & MASK[exp_tgt[m]] & WIN[exp_tgt[m]]);
                exp_we[exp_tgt[m]]   = m_we[m];
                exp_wdat[exp_tgt[m]] = m_wdat[m];
                exp_sel[exp_tgt[m]]  = m_sel[m];
            end
        end
    end

    // Last master that got a response, 2 for none yet
    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            last_m <= 2'd2;
        end else if (m_any[0]) begin
            last_m <= 2'd0;
        end else if (m_any[1]) begin
            last_m <= 2'd1;
        end
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Run stopped at the cycle limit of %0d", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    function automatic string mst_name(input int m);
        return (m == 0) ? "bm" : "rack";
    endfunction

    function automatic string tgt_name(input int t);
        case (t)
            1: return "tio";
            2: return "notch";
            3: return "agc";
            4: return "beam";
            default: return "rfdc";
        endcase
    endfunction

    assert property (@(posedge clk_i) disable iff (!rst_n_i) $onehot0(t_cyc))
        else begin
            $display("More than one target was selected at once");
            errors++;
        end
    assert property (@(posedge clk_i) disable iff (!rst_n_i) !(m_any[0] && m_any[1]))
        else begin
            $display("Both masters got a response in the same cycle");
            errors++;
        end
    // id/ctrl answers two cycles after bm opens a cycle on an idle bus
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ($rose(m_cyc[0]) && !m_cyc[1] && exp_tgt[0] == 0) |->
            !m_any[0] ##1 !m_any[0] ##1 m_any[0])
        else begin
            $display("id/ctrl response missed its two-cycle slot");
            errors++;
        end

    for (genvar g = 0; g < 2; g++) begin : g_mst
        assert property (@(posedge clk_i) disable iff (!rst_n_i) m_any[g] |-> m_cyc[g] && m_stb[g])
            else begin
                $display("Master %s got a response with no cycle open", mst_name(g));
                errors++;
            end
        assert property (@(posedge clk_i) disable iff (!rst_n_i)
            m_any[g] |-> {m_ack[g], m_err[g], m_rty[g]} == exp_rsp[g])
            else begin
                $display("ERROR %0t %s_ack/err/rty got %b expected %b", $time, mst_name(g),
                         $sampled({m_ack[g], m_err[g], m_rty[g]}), $sampled(exp_rsp[g]));
                errors++;
            end
        assert property (@(posedge clk_i) disable iff (!rst_n_i)
            (m_any[g] && !m_we[g]) |-> m_rdat[g] == exp_dat[g])
            else begin
                $display("ERROR %0t %s_dat_o got %h expected %h", $time, mst_name(g),
                         $sampled(m_rdat[g]), $sampled(exp_dat[g]));
                errors++;
            end
        assert property (@(posedge clk_i) disable iff (!rst_n_i)
            (arb_phase && m_any[g]) |-> last_m != 2'(g))
            else begin
                $display("Master %s won twice in a row", mst_name(g));
                errors++;
            end
    end

    for (genvar g = 1; g < 6; g++) begin : g_tgt
        assert property (@(posedge clk_i) disable iff (!rst_n_i) t_cyc[g] |-> pend[g])
            else begin
                $display("Target %s selected with no cycle meant for it", tgt_name(g));
                errors++;
            end
        assert property (@(posedge clk_i) disable iff (!rst_n_i) t_stb[g] == t_cyc[g])
            else begin
                $display("ERROR %0t %s_stb_o got %b expected %b", $time, tgt_name(g),
                         $sampled(t_stb[g]), $sampled(t_cyc[g]));
                errors++;
            end
        assert property (@(posedge clk_i) disable iff (!rst_n_i) t_cyc[g] |-> t_adr[g] == exp_a[g])
            else begin
                $display("ERROR %0t %s_adr_o got %h expected %h", $time, tgt_name(g),
                         $sampled(t_adr[g]), $sampled(exp_a[g]));
                errors++;
            end
        // Write enable, data and byte selects come from the owner
        assert property (@(posedge clk_i) disable iff (!rst_n_i)
            t_cyc[g] |-> {t_we[g], t_wdat[g], t_sel[g]} == {exp_we[g], exp_wdat[g], exp_sel[g]})
            else begin
                $display("ERROR %0t %s_we/dat/sel got %b/%h/%h expected %b/%h/%h", $time,
                         tgt_name(g), $sampled(t_we[g]), $sampled(t_wdat[g]),
                         $sampled(t_sel[g]), $sampled(exp_we[g]), $sampled(exp_wdat[g]),
                         $sampled(exp_sel[g]));
                errors++;
            end
        // The owner keeps the bus until its target answers
        assert property (@(posedge clk_i) disable iff (!rst_n_i)
            (t_cyc[g] && !(t_ack[g] || t_err[g] || t_rty[g])) |=> t_cyc[g])
            else begin
                $display("Target %s lost its cycle before it answered", tgt_name(g));
                errors++;
            end
    end

    // External target models, answering after a random 0 to 3 cycle wait
    initial begin : responder
        int t_act;
        int k;
        wait_idx = 0;
        forever begin
            @(posedge clk_i);
            t_act = 0;
            for (int t = 1; t < 6; t++) begin
                if (t_cyc[t] && t_stb[t]) begin
                    t_act = t;
                end
            end
            if (t_act > 0) begin
                k = wait_tab[wait_idx % 64];
                wait_idx++;
                repeat (k) @(posedge clk_i);
                #2;
                t_dat[t_act] = TAG[t_act] ^ 32'(t_adr[t_act]);
                {t_ack[t_act], t_err[t_act], t_rty[t_act]} = rsp_mode[t_act];
                @(posedge clk_i);
                #2;
                {t_ack[t_act], t_err[t_act], t_rty[t_act]} = 3'b000;
            end
        end
    end

    task automatic bus_access(input int m, input surf_bus_pkg::bus_addr_t adr, input logic we,
                              input surf_bus_pkg::bus_data_t wdat,
                              input surf_bus_pkg::bus_sel_t sel, input int tgt,
                              input surf_bus_pkg::bus_data_t dat_exp, input logic [2:0] rsp_exp);
        int n;
        @(posedge clk_i);
        #2;
        exp_tgt[m] = tgt;
        exp_rsp[m] = rsp_exp;
        // External targets answer with their tag XORed with the address they see
        if (tgt > 0) begin
            exp_dat[m] = TAG[tgt] ^ 32'(adr & MASK[tgt] & WIN[tgt]);
        end else begin
            exp_dat[m] = dat_exp;
        end
        m_adr[m]  = adr;
        m_we[m]   = we;
        m_wdat[m] = wdat;
        m_sel[m]  = sel;
        m_cyc[m]  = 1'b1;
        m_stb[m]  = 1'b1;
        n = 0;
        @(posedge clk_i);
        while (!m_any[m] && n < RSP_LIMIT) begin
            @(posedge clk_i);
            n++;
        end
        if (n >= RSP_LIMIT) begin
            $display("Master %s got no response at address %h", mst_name(m), adr);
            errors++;
        end
        #2;
        m_cyc[m]   = 1'b0;
        m_stb[m]   = 1'b0;
        m_we[m]    = 1'b0;
        exp_tgt[m] = -1;
    endtask

    task automatic report(input int num, input string name);
        repeat (2) @(posedge clk_i);
        if (errors == err_mark) begin
            n_pass++;
            $display("Test %0d %s: pass", num, name);
        end else begin
            n_fail++;
            $display("Test %0d %s: FAIL with %0d errors", num, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    initial begin : main
        void'($urandom(32'h38fc));
        for (int i = 0; i < 64; i++) begin
            wait_tab[i] = int'($urandom % 4);
        end
        rst_n_i   = 1'b0;
        arb_phase = 1'b0;
        m_cyc     = '0;
        m_stb     = '0;
        m_we      = '0;
        t_ack     = '0;
        t_err     = '0;
        t_rty     = '0;
        for (int m = 0; m < 2; m++) begin
            m_adr[m]   = '0;
            m_wdat[m]  = '0;
            m_sel[m]   = '0;
            exp_tgt[m] = -1;
            exp_dat[m] = '0;
            exp_rsp[m] = RSP_ACK;
        end
        for (int t = 0; t < 6; t++) begin
            t_dat[t]    = '0;
            rsp_mode[t] = RSP_ACK;
        end
        repeat (16) @(posedge clk_i);
        #2;
        rst_n_i = 1'b1;

        repeat (4) @(posedge clk_i);
        report(1, "idle after reset");

        for (int t = 1; t < 6; t++) begin
            bus_access(0, BASE[t] | 22'h0000A4, 1'b0, '0, 4'hF, t, '0, RSP_ACK);
        end
        report(2, "decode");

        for (int t = 1; t < 6; t++) begin
            bus_access(0, BASE[t] | 22'h0000A4 | SHADOW, 1'b0, '0, 4'hF, t, '0, RSP_ACK);
        end
        report(3, "shadowing");

        bus_access(0, 22'h000000, 1'b0, '0, 4'hF, 0, `SURF_ID_WORD, RSP_ACK);
        bus_access(0, 22'h000004, 1'b1, 32'h11223344, 4'hF, 0, '0, RSP_ACK);
        bus_access(0, 22'h000004, 1'b1, 32'hAABBCCDD, 4'b0101, 0, '0, RSP_ACK);
        // Lanes 0 and 2 take the second write
        bus_access(0, 22'h000004, 1'b0, '0, 4'hF, 0, 32'h11BB33DD, RSP_ACK);
        bus_access(0, 22'h000008, 1'b0, '0, 4'hF, 0, '0, RSP_ERR);
        report(4, "id/ctrl");

        // bm owned the bus last, so rack wins the first simultaneous request
        arb_phase = 1'b1;
        fork
            begin
                for (int i = 0; i < 4; i++) begin
                    bus_access(0, BASE[2] | 22'(16 * i), 1'b0, '0, 4'hF, 2, '0, RSP_ACK);
                end
            end
            begin
                for (int i = 0; i < 4; i++) begin
                    bus_access(1, BASE[3] | 22'(8 * i), 1'b1, 32'hA5A50000 | 32'(i),
                               4'(1 << i), 3, '0, RSP_ACK);
                end
            end
        join
        arb_phase = 1'b0;
        report(5, "arbitration");

        rsp_mode[1] = RSP_ERR;
        rsp_mode[4] = RSP_RTY;
        fork
            bus_access(0, BASE[1] | 22'h000010, 1'b0, '0, 4'hF, 1, '0, RSP_ERR);
            bus_access(1, BASE[4] | 22'h000020, 1'b0, '0, 4'hF, 4, '0, RSP_RTY);
        join
        rsp_mode[1] = RSP_ACK;
        rsp_mode[4] = RSP_ACK;
        report(6, "error and retry routing");

        $display("Tests passed %0d, failed %0d, errors %0d", n_pass, n_fail, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
